/* all.f */
+incdir+include
hw/prbs_pkg.sv
hw/prbs_generator.sv
hw/prbs_delay_line.sv
hw/prbs_checker_core.sv
hw/prbs_link_top.sv
testbench/tb_prbs_link.sv

/* hw/prbs_checker_core.sv */
`timescale 1ns/1ns

`include "prbs_config.svh"

module prbs_checker_core (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   prbs_cke,
    input  prbs_pkg::rx_word_t     rx_word,
    input  logic                   word_valid,
    input  prbs_pkg::lane_shift_t  rx_shift,
    output logic                   match,
    output prbs_pkg::match_count_t match_bits,
    output logic                   match_valid
);

    logic [2*`PRBS_CHANNELS-1:0] rx_dbl;
    prbs_pkg::rx_word_t          rx_rot;
    prbs_pkg::prbs_state_t       lane_state [`PRBS_CHANNELS];
    prbs_pkg::rx_word_t          lane_pred;
    prbs_pkg::rx_word_t          lane_in;
    prbs_pkg::rx_word_t          lane_eq;
    prbs_pkg::match_count_t      eq_count;

    // rotate right by rx_shift
    // lane i takes word bit (i + rx_shift) mod 16
    assign rx_dbl = {rx_word, rx_word} >> rx_shift;
    assign rx_rot = rx_dbl[`PRBS_CHANNELS-1:0];

    // per lane prediction and compare
    // a 16x decimated PRBS7 is the same m-sequence, so each lane
    // uses the generator polynomial on its own slow stream
    always_comb begin
        for (int i = 0; i < `PRBS_CHANNELS; i++) begin
            lane_pred[i] = lane_state[i][`PRBS_N-1] ^ lane_state[i][`PRBS_N-2];
            lane_eq[i]   = ~(lane_pred[i] ^ rx_rot[i]);
            // load from the line while unlocked, free run once locked
            lane_in[i]   = prbs_cke ? lane_pred[i] : rx_rot[i];
        end
    end

    // number of matching lanes
    always_comb begin
        eq_count = '0;
        for (int i = 0; i < `PRBS_CHANNELS; i++) begin
            eq_count = eq_count + prbs_pkg::match_count_t'(lane_eq[i]);
        end
    end

    // lane predictors, one step per word
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `PRBS_CHANNELS; i++) begin
                lane_state[i] <= prbs_pkg::lane_seeds[i];
            end
        end else if (word_valid) begin
            for (int i = 0; i < `PRBS_CHANNELS; i++) begin
                lane_state[i] <= {lane_state[i][`PRBS_N-2:0], lane_in[i]};
            end
        end
    end

    // results, registered once per word
    always_ff @(posedge clk) begin
        if (rst) begin
            match       <= 1'b0;
            match_bits  <= '0;
            match_valid <= 1'b0;
        end else begin
            match_valid <= word_valid;
            if (word_valid) begin
                match      <= &lane_eq;
                match_bits <= eq_count;
            end
        end
    end

endmodule

/* hw/prbs_delay_line.sv */
`timescale 1ns/1ns

`include "prbs_config.svh"

module prbs_delay_line (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      prbs_bit,
    input  logic [`PRBS_DEL_BITS-1:0] prbs_del,
    output prbs_pkg::rx_word_t        rx_word,
    output logic                      word_valid
);

    // enough bits to address the top of the history plus the live bit
    localparam int top_w   = $clog2(`PRBS_HIST_BITS + 1);
    localparam int phase_w = $clog2(`PRBS_CHANNELS);

    logic [`PRBS_HIST_BITS-1:0] hist;
    logic [`PRBS_HIST_BITS:0]   hist_all;
    logic [top_w-1:0]           win_top;
    prbs_pkg::rx_word_t         window;
    logic [phase_w-1:0]         phase;
    logic                       phase_last;

    // bit history
    // new bits enter at the top, oldest bit sits at index 0
    always_ff @(posedge clk) begin
        if (rst) begin
            hist <= '0;
        end else begin
            hist <= {prbs_bit, hist[`PRBS_HIST_BITS-1:1]};
        end
    end

    // the live bit sits above the stored history
    assign hist_all = {prbs_bit, hist};

    // window ends prbs_del places below the newest bit
    assign win_top = top_w'(`PRBS_HIST_BITS) - top_w'(prbs_del);
    assign window  = hist_all[win_top -: `PRBS_CHANNELS];

    // free running word phase
    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= '0;
        end else begin
            phase <= phase + 1'b1;
        end
    end

    assign phase_last = (phase == phase_w'(`PRBS_CHANNELS - 1));

    // capture the window on the last phase, strobe one cycle later
    always_ff @(posedge clk) begin
        if (rst) begin
            word_valid <= 1'b0;
        end else begin
            word_valid <= phase_last;
        end
    end

    // rx_word holds between strobes
    always_ff @(posedge clk) begin
        if (phase_last) begin
            rx_word <= window;
        end
    end

endmodule

/* hw/prbs_generator.sv */
`timescale 1ns/1ns

`include "prbs_config.svh"

module prbs_generator (
    input  logic clk,
    input  logic rst,
    input  logic err_inject,
    output logic prbs_bit
);

    prbs_pkg::prbs_state_t state;
    logic                  feedback;
    logic                  bit_q;

    // taps at stages 7 and 6
    assign feedback = state[`PRBS_N-1] ^ state[`PRBS_N-2];

    // fibonacci LFSR, steps every cycle
    // the stream starts from lane 0's seed
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= prbs_pkg::lane_seeds[0];
        end else begin
            state <= {state[`PRBS_N-2:0], feedback};
        end
    end

    // the newest state bit is sent one cycle after the step
    always_ff @(posedge clk) begin
        if (rst) begin
            bit_q <= 1'b0;
        end else begin
            bit_q <= state[0];
        end
    end

    // error injection flips only the emitted bit, the LFSR runs on untouched
    assign prbs_bit = bit_q ^ err_inject;

endmodule

/* hw/prbs_link_top.sv */
`timescale 1ns/1ns

`include "prbs_config.svh"

module prbs_link_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      err_inject,
    input  logic [`PRBS_DEL_BITS-1:0] prbs_del,
    input  prbs_pkg::lane_shift_t     rx_shift,
    input  logic                      prbs_cke,
    output logic                      match,
    output prbs_pkg::match_count_t    match_bits,
    output logic                      match_valid
);

    logic               prbs_bit;
    prbs_pkg::rx_word_t rx_word;
    logic               word_valid;

    // serial stream source
    prbs_generator u_generator (
        .clk        (clk),
        .rst        (rst),
        .err_inject (err_inject),
        .prbs_bit   (prbs_bit)
    );

    // history, delayed window and deserializer
    prbs_delay_line u_delay_line (
        .clk        (clk),
        .rst        (rst),
        .prbs_bit   (prbs_bit),
        .prbs_del   (prbs_del),
        .rx_word    (rx_word),
        .word_valid (word_valid)
    );

    // 16 lane checker
    prbs_checker_core u_checker (
        .clk         (clk),
        .rst         (rst),
        .prbs_cke    (prbs_cke),
        .rx_word     (rx_word),
        .word_valid  (word_valid),
        .rx_shift    (rx_shift),
        .match       (match),
        .match_bits  (match_bits),
        .match_valid (match_valid)
    );

endmodule

/* hw/prbs_pkg.sv */
`include "prbs_config.svh"

package prbs_pkg;

    // one LFSR state, newest bit in bit 0
    typedef logic [`PRBS_N-1:0] prbs_state_t;

    // one deserialized word, bit i belongs to lane i
    typedef logic [`PRBS_CHANNELS-1:0] rx_word_t;

    // lane rotation amount
    typedef logic [$clog2(`PRBS_CHANNELS)-1:0] lane_shift_t;

    // matching lanes, 0 up to the full lane count
    typedef logic [$clog2(`PRBS_CHANNELS):0] match_count_t;

    // reset seeds of the lane predictors, all nonzero
    localparam prbs_state_t lane_seeds [`PRBS_CHANNELS] = '{
        7'd3,
        7'd10,
        7'd60,
        7'd11,
        7'd58,
        7'd31,
        7'd67,
        7'd9,
        7'd54,
        7'd55,
        7'd49,
        7'd37,
        7'd92,
        7'd74,
        7'd63,
        7'd1
    };

endpackage

/* include/prbs_config.svh */
`ifndef PRBS_CONFIG_SVH
`define PRBS_CONFIG_SVH

// PRBS order, polynomial x^7 + x^6 + 1
`define PRBS_N 7

// lanes in the checker, also the deserializer word width
// must stay a power of two so every lane sees the same m-sequence
`define PRBS_CHANNELS 16

// depth of the serial bit history in the delay line
`define PRBS_HIST_BITS 270

// width of the delay select
// largest delay (255) still leaves a full word inside the history
`define PRBS_DEL_BITS 8

`endif

/* testbench/tb_prbs_link.sv */
`timescale 1ns/1ns

`include "prbs_config.svh"

module tb_prbs_link;

    localparam int word_len          = `PRBS_CHANNELS;
    localparam int reset_cycles      = 10;
    // 271 history bits plus the reset bit need 18 words to flush
    localparam int fill_words        = 18;
    localparam int lock_words        = 8;
    localparam int settle_words      = 2;
    localparam int check_words       = 16;
    localparam int inject_count      = 12;
    localparam int inject_gap_max    = 48;
    localparam int rounds            = 4;
    localparam int round_high_words  = 6;
    localparam int round_check_words = 6;

    localparam int t1_len = reset_cycles + fill_words * word_len;
    localparam int t2_len = (lock_words + settle_words + check_words) * word_len;
    localparam int t3_len = inject_count * inject_gap_max + fill_words * word_len;
    localparam int t4_len = rounds * word_len
                          * (round_high_words + lock_words + settle_words + round_check_words);
    localparam int t5_len = word_len + reset_cycles
                          + (round_high_words + fill_words + settle_words + check_words) * word_len;
    localparam int cycle_limit = (t1_len + t2_len + t3_len + t4_len + t5_len) * 3 / 2;

    logic                      clk;
    logic                      rst;
    logic                      err_inject;
    logic [`PRBS_DEL_BITS-1:0] prbs_del;
    prbs_pkg::lane_shift_t     rx_shift;
    logic                      prbs_cke;
    logic                      match;
    prbs_pkg::match_count_t    match_bits;
    logic                      match_valid;

    integer      seed;
    logic [31:0] rnd;
    int          err_count;
    int          cycle_count;
    int          words_seen;
    int          full_words;
    int          one_off_words;

    // reference model state
    bit                     armed;
    prbs_pkg::prbs_state_t  gen_state;
    logic                   gen_bit;
    logic                   hist_m [1:`PRBS_HIST_BITS];
    int                     phase_m;
    logic                   wv_m;
    prbs_pkg::rx_word_t     rxw_m;
    prbs_pkg::prbs_state_t  lane_m [`PRBS_CHANNELS];
    logic                   match_m;
    prbs_pkg::match_count_t bits_m;
    logic                   valid_m;

    prbs_link_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .err_inject  (err_inject),
        .prbs_del    (prbs_del),
        .rx_shift    (rx_shift),
        .prbs_cke    (prbs_cke),
        .match       (match),
        .match_bits  (match_bits),
        .match_valid (match_valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run();
        err_count++;
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic report_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        $display("Fail at %0t ns: %s expected %0d got %0d", $time, name, expected, actual);
        abort_run();
    endtask

    task automatic report_error(input string what);
        $display("at %0t ns: %s", $time, what);
        abort_run();
    endtask

    task automatic run_words(input int n);
        repeat (n * word_len) @(posedge clk);
    endtask

    // every word in the next n must match on all lanes
    task automatic expect_full_match(input int n);
        int total0;
        int full0;
        total0 = words_seen;
        full0  = full_words;
        run_words(n);
        assert (words_seen - total0 == n && full_words - full0 == n)
        else report_error("lanes did not hold full match after locking");
    endtask

    // single bit errors spaced more than a word apart
    task automatic inject_errors();
        int total0;
        int full0;
        int single0;
        total0  = words_seen;
        full0   = full_words;
        single0 = one_off_words;
        for (int j = 0; j < inject_count; j++) begin
            rnd = $random(seed);
            repeat (word_len + rnd[4:0]) @(posedge clk);
            err_inject <= 1'b1;
            @(posedge clk);
            err_inject <= 1'b0;
        end
        // the last error can sit up to the full history depth in the delay line
        run_words(fill_words);
        assert (one_off_words - single0 == inject_count)
        else report_error("injected errors did not each hit exactly one word");
        assert (full_words - full0 + one_off_words - single0 == words_seen - total0)
        else report_error("a word outside the injected ones lost its match");
    endtask

    task automatic change_and_relock();
        rnd = $random(seed);
        case (rnd[1:0])
            2'd0: prbs_del <= rnd[15:8];
            2'd1: rx_shift <= rnd[19:16];
            default: begin
                prbs_del <= rnd[15:8];
                rx_shift <= rnd[19:16];
            end
        endcase
        run_words(round_high_words);
        prbs_cke <= 1'b0;
        run_words(lock_words);
        prbs_cke <= 1'b1;
        run_words(settle_words);
        expect_full_match(round_check_words);
    endtask

    task automatic reset_mid_run();
        rnd = $random(seed);
        repeat (rnd[3:0]) @(posedge clk);
        rst <= 1'b1;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
        // lanes free run from their seeds against a cleared history
        run_words(round_high_words);
        prbs_cke <= 1'b0;
        run_words(fill_words);
        prbs_cke <= 1'b1;
        run_words(settle_words);
        expect_full_match(check_words);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        assert (cycle_count < cycle_limit)
        else report_error("run did not finish within its cycle limit");
    end

    // cycle model of the link, compared before it steps
    always @(posedge clk) begin : model_step
        logic live;
        logic pred;
        logic rbit;
        int   eq_cnt;
        int   age;
        if (armed) begin
            assert (match_valid === valid_m)
            else begin
                if (valid_m) begin
                    report_error("match_valid missing one cycle after a word strobe");
                end else begin
                    report_error("match_valid pulsed without a word strobe");
                end
            end
            assert (match === match_m) else report_value("match", match_m, match);
            assert (match_bits === bits_m) else report_value("match_bits", bits_m, match_bits);
            if (match_valid) begin
                words_seen <= words_seen + 1;
                if (match_bits == word_len) begin
                    full_words <= full_words + 1;
                end
                if (match_bits == word_len - 1) begin
                    one_off_words <= one_off_words + 1;
                end
            end
        end
        if (rst) begin
            gen_state = prbs_pkg::lane_seeds[0];
            gen_bit   = 1'b0;
            for (int k = 1; k <= `PRBS_HIST_BITS; k++) begin
                hist_m[k] = 1'b0;
            end
            for (int i = 0; i < `PRBS_CHANNELS; i++) begin
                lane_m[i] = prbs_pkg::lane_seeds[i];
            end
            phase_m = 0;
            wv_m    = 1'b0;
            valid_m = 1'b0;
            match_m = 1'b0;
            bits_m  = '0;
            armed   = 1'b1;
        end else begin
            live = gen_bit ^ err_inject;
            // lanes step on the word strobe
            if (wv_m) begin
                eq_cnt = 0;
                for (int i = 0; i < `PRBS_CHANNELS; i++) begin
                    rbit = rxw_m[(i + int'(rx_shift)) % word_len];
                    pred = lane_m[i][6] ^ lane_m[i][5];
                    if (pred == rbit) begin
                        eq_cnt++;
                    end
                    lane_m[i] = {lane_m[i][5:0], prbs_cke ? pred : rbit};
                end
                match_m = (eq_cnt == word_len);
                bits_m  = prbs_pkg::match_count_t'(eq_cnt);
            end
            valid_m = wv_m;
            // word bit i is the bit from prbs_del + 15 - i cycles back, age 0 is live
            if (phase_m == word_len - 1) begin
                for (int i = 0; i < `PRBS_CHANNELS; i++) begin
                    age      = int'(prbs_del) + word_len - 1 - i;
                    rxw_m[i] = (age == 0) ? live : hist_m[age];
                end
            end
            wv_m    = (phase_m == word_len - 1);
            phase_m = (phase_m + 1) % word_len;
            for (int k = `PRBS_HIST_BITS; k > 1; k--) begin
                hist_m[k] = hist_m[k-1];
            end
            hist_m[1] = live;
            gen_bit   = gen_state[0];
            gen_state = {gen_state[5:0], gen_state[6] ^ gen_state[5]};
        end
    end

    initial begin
        seed          = 32'hcb8f_21dc;
        err_count     = 0;
        cycle_count   = 0;
        words_seen    = 0;
        full_words    = 0;
        one_off_words = 0;
        armed         = 1'b0;
        rnd           = $random(seed);
        rst           = 1'b1;
        err_inject    = 1'b0;
        prbs_cke      = 1'b0;
        prbs_del      = rnd[7:0];
        rx_shift      = rnd[11:8];

        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
        run_words(fill_words);
        // first strobe 17 cycles after reset, then one per word
        assert (words_seen == fill_words - 1)
        else report_error("wrong number of match_valid pulses after reset");

        run_words(lock_words);
        prbs_cke <= 1'b1;
        run_words(settle_words);
        expect_full_match(check_words);

        inject_errors();

        for (int r = 0; r < rounds; r++) begin
            change_and_relock();
        end

        reset_mid_run();

        if (err_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
